// File: hdl/ps_bus_settings.svh
//////////////////////////////////////////////////
// System bus settings
// Widths and region decode of the PS side bus
//////////////////////////////////////////////////

`ifndef PS_BUS_SETTINGS_SVH
`define PS_BUS_SETTINGS_SVH

// Address and data width, shared by AXI and system bus
`define SYS_AW 32
`define SYS_DW 32

// One byte select per data byte
`define SYS_SW (`SYS_DW/8)

// AXI ID width of the GP port
`define AXI_IW 12

// Region field inside the address
`define SYS_REGION_LSB 20
`define SYS_REGION_W 2

// Mapped regions, the rest answer with error
`define SYS_NSLV 2

`endif

// File: hdl/ps_bus_pkg.sv
//////////////////////////////////////////////////
// System bus package
// Shared bus and AXI response types
//////////////////////////////////////////////////

`include "ps_bus_settings.svh"

package ps_bus_pkg;

  // System bus word types
  typedef logic [`SYS_AW-1:0] sys_addr_t;
  typedef logic [`SYS_DW-1:0] sys_data_t;
  typedef logic [`SYS_SW-1:0] sys_sel_t;

  // AXI transaction ID
  typedef logic [`AXI_IW-1:0] axi_id_t;

  // AXI response codes
  // EXOKAY and DECERR never produced here
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_t;

endpackage

// File: hdl/sys_bus_if.sv
//////////////////////////////////////////////////
// System bus interface
// Strobe and ack bus between bridge and blocks
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface sys_bus_if (
  input logic clk,
  input logic rstn
);

  // Request side
  ps_bus_pkg::sys_addr_t addr;
  ps_bus_pkg::sys_data_t wdata;
  ps_bus_pkg::sys_sel_t  sel;
  // One cycle strobes
  logic                  wen;
  logic                  ren;

  // Response side, valid with ack
  ps_bus_pkg::sys_data_t rdata;
  logic                  ack;
  logic                  err;

  modport m (input clk, rstn, output addr, wdata, sel, wen, ren, input rdata, ack, err);
  modport s (input clk, rstn, addr, wdata, sel, wen, ren, output rdata, ack, err);

endinterface

// File: hdl/axi4_slave.sv
//////////////////////////////////////////////////
// AXI single beat slave
// Bridges AXI channels onto one system bus access
// and returns ack and err as a held AXI response
//////////////////////////////////////////////////

`timescale 1ns/1ps

module axi4_slave (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // Write address channel
  input  logic                  awvalid_i,
  output logic                  awready_o,
  input  ps_bus_pkg::sys_addr_t awaddr_i,
  input  ps_bus_pkg::axi_id_t   awid_i,
  // Write data channel
  input  logic                  wvalid_i,
  output logic                  wready_o,
  input  ps_bus_pkg::sys_data_t wdata_i,
  input  ps_bus_pkg::sys_sel_t  wstrb_i,
  // Write response channel
  output logic                  bvalid_o,
  input  logic                  bready_i,
  output ps_bus_pkg::axi_resp_t bresp_o,
  output ps_bus_pkg::axi_id_t   bid_o,
  // Read address channel
  input  logic                  arvalid_i,
  output logic                  arready_o,
  input  ps_bus_pkg::sys_addr_t araddr_i,
  input  ps_bus_pkg::axi_id_t   arid_i,
  // Read data channel
  output logic                  rvalid_o,
  input  logic                  rready_i,
  output ps_bus_pkg::axi_resp_t rresp_o,
  output ps_bus_pkg::axi_id_t   rid_o,
  output ps_bus_pkg::sys_data_t rdata_o,
  // System bus master side
  sys_bus_if.m                  bus
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WACK,
    ST_BRESP,
    ST_RACK,
    ST_RRESP
  } state_t;

  state_t state;

  // Channel held flags
  logic aw_held;
  logic w_held;
  logic ar_held;

  // Captured channel payload
  ps_bus_pkg::sys_addr_t awaddr_q;
  ps_bus_pkg::axi_id_t   awid_q;
  ps_bus_pkg::sys_data_t wdata_q;
  ps_bus_pkg::sys_sel_t  wstrb_q;
  ps_bus_pkg::sys_addr_t araddr_q;
  ps_bus_pkg::axi_id_t   arid_q;

  //////////////////////////////////////////////////
  // Channel acceptance
  //////////////////////////////////////////////////

  // Ready only while idle and the channel is still empty
  assign awready_o = (state == ST_IDLE) && !aw_held;
  assign wready_o  = (state == ST_IDLE) && !w_held;
  assign arready_o = (state == ST_IDLE) && !ar_held;

  always_ff @(posedge clk_i) begin
    if (awvalid_i && awready_o) begin
      awaddr_q <= awaddr_i;
      awid_q   <= awid_i;
    end
    if (wvalid_i && wready_o) begin
      wdata_q <= wdata_i;
      wstrb_q <= wstrb_i;
    end
    if (arvalid_i && arready_o) begin
      araddr_q <= araddr_i;
      arid_q   <= arid_i;
    end
    // Read data taken with the ack
    if ((state == ST_RACK) && bus.ack) begin
      rdata_o <= bus.rdata;
    end
  end

  //////////////////////////////////////////////////
  // Transaction FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state    <= ST_IDLE;
      aw_held  <= 1'b0;
      w_held   <= 1'b0;
      ar_held  <= 1'b0;
      bus.wen  <= 1'b0;
      bus.ren  <= 1'b0;
      bvalid_o <= 1'b0;
      rvalid_o <= 1'b0;
      bresp_o  <= ps_bus_pkg::OKAY;
      rresp_o  <= ps_bus_pkg::OKAY;
    end else begin
      // Strobes last one cycle
      bus.wen <= 1'b0;
      bus.ren <= 1'b0;
      if (awvalid_i && awready_o) aw_held <= 1'b1;
      if (wvalid_i && wready_o)   w_held  <= 1'b1;
      if (arvalid_i && arready_o) ar_held <= 1'b1;
      case (state)
        ST_IDLE: begin
          // Complete write wins over a pending read
          if (aw_held && w_held) begin
            bus.wen <= 1'b1;
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            state   <= ST_WACK;
          end else if (ar_held) begin
            bus.ren <= 1'b1;
            ar_held <= 1'b0;
            state   <= ST_RACK;
          end
        end
        ST_WACK: begin
          if (bus.ack) begin
            bvalid_o <= 1'b1;
            bresp_o  <= bus.err ? ps_bus_pkg::SLVERR : ps_bus_pkg::OKAY;
            state    <= ST_BRESP;
          end
        end
        ST_BRESP: begin
          if (bready_i) begin
            bvalid_o <= 1'b0;
            state    <= ST_IDLE;
          end
        end
        ST_RACK: begin
          if (bus.ack) begin
            rvalid_o <= 1'b1;
            rresp_o  <= bus.err ? ps_bus_pkg::SLVERR : ps_bus_pkg::OKAY;
            state    <= ST_RRESP;
          end
        end
        ST_RRESP: begin
          if (rready_i) begin
            rvalid_o <= 1'b0;
            state    <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Address stays put until ack, no new AW or AR taken meanwhile
  assign bus.addr  = (state == ST_WACK) ? awaddr_q : araddr_q;
  assign bus.wdata = wdata_q;
  assign bus.sel   = wstrb_q;

  // IDs echo the captured request
  assign bid_o = awid_q;
  assign rid_o = arid_q;

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Write response held under back-pressure
  a_bresp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o));

  // Read data held under back-pressure
  a_rdata_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o));

  a_one_strobe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(bus.wen && bus.ren));

endmodule

// File: hdl/sys_bus_interconnect.sv
//////////////////////////////////////////////////
// System bus interconnect
// Routes accesses by address region, errors on
// unmapped regions
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "ps_bus_settings.svh"

module sys_bus_interconnect (
  input  logic clk_i,
  input  logic rst_n_i,
  // From the bridge
  sys_bus_if.s bus,
  // Towards the register blocks
  sys_bus_if.m sub [`SYS_NSLV-1:0]
);

  // Region field of the current access
  logic [`SYS_REGION_W-1:0] region;
  logic                     unmapped;

  // Gathered sub-bus responses
  logic [`SYS_NSLV-1:0]  sub_ack;
  logic [`SYS_NSLV-1:0]  sub_err;
  ps_bus_pkg::sys_data_t sub_rdata [`SYS_NSLV];

  // One flop error responder
  logic unm_ack;

  assign region   = bus.addr[`SYS_REGION_LSB +: `SYS_REGION_W];
  assign unmapped = (region >= `SYS_NSLV);

  //////////////////////////////////////////////////
  // Request fan-out
  //////////////////////////////////////////////////

  for (genvar i = 0; i < `SYS_NSLV; i++) begin : g_sub
    // Offset inside region only
    assign sub[i].addr  = {{(`SYS_AW-`SYS_REGION_LSB){1'b0}},
                           bus.addr[`SYS_REGION_LSB-1:0]};
    assign sub[i].wdata = bus.wdata;
    assign sub[i].sel   = bus.sel;
    // Strobe only to the hit region
    assign sub[i].wen   = bus.wen && (region == `SYS_REGION_W'(i));
    assign sub[i].ren   = bus.ren && (region == `SYS_REGION_W'(i));
    assign sub_ack[i]   = sub[i].ack;
    assign sub_err[i]   = sub[i].err;
    assign sub_rdata[i] = sub[i].rdata;
  end

  // Unmapped access, ack with error one cycle later
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      unm_ack <= 1'b0;
    end else begin
      unm_ack <= (bus.wen || bus.ren) && unmapped;
    end
  end

  //////////////////////////////////////////////////
  // Response mux
  //////////////////////////////////////////////////

  // Address held until ack, so region still selects the responder
  always_comb begin
    bus.ack   = unm_ack;
    bus.err   = unm_ack;
    bus.rdata = '0;
    for (int i = 0; i < `SYS_NSLV; i++) begin
      if (int'(region) == i) begin
        bus.ack   = sub_ack[i];
        bus.err   = sub_err[i];
        bus.rdata = sub_rdata[i];
      end
    end
  end

  // Never two responders in the same cycle
  a_one_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({sub_ack, unm_ack}));

endmodule

// File: hdl/sys_bus_regs.sv
//////////////////////////////////////////////////
// System bus register block
// ID, scratch, GPIO out and synced GPIO in
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "ps_bus_settings.svh"

module sys_bus_regs #(
  parameter logic [31:0] ID_VALUE = 32'h0000_0000
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  sys_bus_if.s       bus,
  // GPIO pins
  input  logic [7:0] gpio_i,
  output logic [7:0] gpio_o
);

  // Register offsets
  localparam ps_bus_pkg::sys_addr_t OFS_ID  = 'h0;
  localparam ps_bus_pkg::sys_addr_t OFS_SCR = 'h4;
  localparam ps_bus_pkg::sys_addr_t OFS_GPO = 'h8;
  localparam ps_bus_pkg::sys_addr_t OFS_GPI = 'hc;

  ps_bus_pkg::sys_data_t scratch;
  logic [7:0]            gpo;
  // Two flop input synchronizer
  logic [7:0]            gpi_meta;
  logic [7:0]            gpi_sync;

  // Address decode
  logic hit_id, hit_scr, hit_gpo, hit_gpi;
  logic wr_ok, rd_ok;

  assign hit_id  = (bus.addr == OFS_ID);
  assign hit_scr = (bus.addr == OFS_SCR);
  assign hit_gpo = (bus.addr == OFS_GPO);
  assign hit_gpi = (bus.addr == OFS_GPI);
  // ID and GPIO in are read only
  assign wr_ok   = hit_scr || hit_gpo;
  assign rd_ok   = hit_id || hit_scr || hit_gpo || hit_gpi;

  always_ff @(posedge clk_i) begin
    gpi_meta <= gpio_i;
    gpi_sync <= gpi_meta;
  end

  //////////////////////////////////////////////////
  // Writes and response
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      scratch <= '0;
      gpo     <= '0;
      bus.ack <= 1'b0;
      bus.err <= 1'b0;
    end else begin
      bus.ack <= bus.wen || bus.ren;
      bus.err <= (bus.wen && !wr_ok) || (bus.ren && !rd_ok);
      // Byte selected scratch write
      if (bus.wen && hit_scr) begin
        for (int b = 0; b < `SYS_SW; b++) begin
          if (bus.sel[b]) scratch[8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
      // GPIO out lives in byte 0
      if (bus.wen && hit_gpo && bus.sel[0]) gpo <= bus.wdata[7:0];
    end
  end

  // Read data with zero for bad offsets
  always_ff @(posedge clk_i) begin
    if (bus.ren) begin
      if (hit_id)       bus.rdata <= ID_VALUE;
      else if (hit_scr) bus.rdata <= scratch;
      else if (hit_gpo) bus.rdata <= {{(`SYS_DW-8){1'b0}}, gpo};
      else if (hit_gpi) bus.rdata <= {{(`SYS_DW-8){1'b0}}, gpi_sync};
      else              bus.rdata <= '0;
    end
  end

  assign gpio_o = gpo;

  // One cycle strobe, acked on the next cycle with no new strobe
  a_ack_timing: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (bus.wen || bus.ren) |=> bus.ack && !bus.wen && !bus.ren);

endmodule

// File: hdl/red_pitaya_ps_sys.sv
//////////////////////////////////////////////////
// PS side system top
// AXI GP port into system bus and register blocks
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "ps_bus_settings.svh"

module red_pitaya_ps_sys (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // AXI write address
  input  logic                  awvalid_i,
  output logic                  awready_o,
  input  ps_bus_pkg::sys_addr_t awaddr_i,
  input  ps_bus_pkg::axi_id_t   awid_i,
  // AXI write data
  input  logic                  wvalid_i,
  output logic                  wready_o,
  input  ps_bus_pkg::sys_data_t wdata_i,
  input  ps_bus_pkg::sys_sel_t  wstrb_i,
  // AXI write response
  output logic                  bvalid_o,
  input  logic                  bready_i,
  output ps_bus_pkg::axi_resp_t bresp_o,
  output ps_bus_pkg::axi_id_t   bid_o,
  // AXI read address
  input  logic                  arvalid_i,
  output logic                  arready_o,
  input  ps_bus_pkg::sys_addr_t araddr_i,
  input  ps_bus_pkg::axi_id_t   arid_i,
  // AXI read data
  output logic                  rvalid_o,
  input  logic                  rready_i,
  output ps_bus_pkg::axi_resp_t rresp_o,
  output ps_bus_pkg::axi_id_t   rid_o,
  output ps_bus_pkg::sys_data_t rdata_o,
  // GPIO, one byte per region
  input  logic [15:0]           gpio_i,
  output logic [15:0]           gpio_o
);

  // Bridge to interconnect, then one bus per region
  sys_bus_if bus (.clk (clk_i), .rstn (rst_n_i));
  sys_bus_if sub [`SYS_NSLV-1:0] (.clk (clk_i), .rstn (rst_n_i));

  axi4_slave axi_slave_i (
    .clk_i     (clk_i    ), .rst_n_i   (rst_n_i  ),
    .awvalid_i (awvalid_i), .awready_o (awready_o),
    .awaddr_i  (awaddr_i ), .awid_i    (awid_i   ),
    .wvalid_i  (wvalid_i ), .wready_o  (wready_o ),
    .wdata_i   (wdata_i  ), .wstrb_i   (wstrb_i  ),
    .bvalid_o  (bvalid_o ), .bready_i  (bready_i ),
    .bresp_o   (bresp_o  ), .bid_o     (bid_o    ),
    .arvalid_i (arvalid_i), .arready_o (arready_o),
    .araddr_i  (araddr_i ), .arid_i    (arid_i   ),
    .rvalid_o  (rvalid_o ), .rready_i  (rready_i ),
    .rresp_o   (rresp_o  ), .rid_o     (rid_o    ),
    .rdata_o   (rdata_o  ),
    .bus       (bus      )
  );

  sys_bus_interconnect interconnect_i (
    .clk_i   (clk_i  ),
    .rst_n_i (rst_n_i),
    .bus     (bus    ),
    .sub     (sub    )
  );

  // Region 0, low GPIO byte
  sys_bus_regs #(.ID_VALUE (32'h5250_0001)) regs0_i (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .bus (sub[0]),
    .gpio_i (gpio_i[7:0]), .gpio_o (gpio_o[7:0])
  );

  // Region 1, high GPIO byte
  sys_bus_regs #(.ID_VALUE (32'h5250_0002)) regs1_i (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .bus (sub[1]),
    .gpio_i (gpio_i[15:8]), .gpio_o (gpio_o[15:8])
  );

endmodule

// File: test/tb_red_pitaya_ps_sys.sv
//////////////////////////////////////////////////
// Testbench of the PS side system top
// Plays the AXI GP master and checks the register
// blocks against a scoreboard
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "ps_bus_settings.svh"

module tb_red_pitaya_ps_sys;

  localparam int N_TRANS    = 48;
  localparam int RST_CYCLES = 16;
  localparam int CLK_PERIOD = 100;

  // Expected ID word per region
  localparam logic [31:0] ID_VAL [2] = '{32'h5250_0001, 32'h5250_0002};

  logic clk   = 1'b0;
  logic rst_n = 1'b0;

  // AXI master side
  logic awvalid, wvalid, bready, arvalid, rready;
  ps_bus_pkg::sys_addr_t awaddr, araddr;
  ps_bus_pkg::axi_id_t   awid, arid;
  ps_bus_pkg::sys_data_t wdata;
  ps_bus_pkg::sys_sel_t  wstrb;
  logic [15:0]           gpio_i;

  // DUT outputs
  logic awready_o, wready_o, bvalid_o, arready_o, rvalid_o;
  ps_bus_pkg::axi_resp_t bresp_o, rresp_o;
  ps_bus_pkg::axi_id_t   bid_o, rid_o;
  ps_bus_pkg::sys_data_t rdata_o;
  logic [15:0]           gpio_o;

  int          mismatch_cnt = 0;
  int          fail_cnt     = 0;
  logic [31:0] lfsr_state   = 32'hef3;

  // Scoreboard per region
  logic [31:0] scr_model [2];
  logic [7:0]  gpo_model [2];

  always #(CLK_PERIOD/2) clk = ~clk;

  red_pitaya_ps_sys dut_i (
    .clk_i     (clk      ), .rst_n_i   (rst_n    ),
    .awvalid_i (awvalid  ), .awready_o (awready_o),
    .awaddr_i  (awaddr   ), .awid_i    (awid     ),
    .wvalid_i  (wvalid   ), .wready_o  (wready_o ),
    .wdata_i   (wdata    ), .wstrb_i   (wstrb    ),
    .bvalid_o  (bvalid_o ), .bready_i  (bready   ),
    .bresp_o   (bresp_o  ), .bid_o     (bid_o    ),
    .arvalid_i (arvalid  ), .arready_o (arready_o),
    .araddr_i  (araddr   ), .arid_i    (arid     ),
    .rvalid_o  (rvalid_o ), .rready_i  (rready   ),
    .rresp_o   (rresp_o  ), .rid_o     (rid_o    ),
    .rdata_o   (rdata_o  ),
    .gpio_i    (gpio_i   ), .gpio_o    (gpio_o   )
  );

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] addr_of(input int region, input int ofs);
    return (32'(region) << `SYS_REGION_LSB) | 32'(ofs);
  endfunction

  // Byte enable merge of a write into the old word
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0] strb);
    logic [31:0] r;
    r = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) r[8*b +: 8] = new_w[8*b +: 8];
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      mismatch_cnt++;
      $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    assert (cond) else begin
      fail_cnt++;
      $display("Failure: %s at %0t", what, $time);
    end
  endtask

  //////////////////////////////////////////////////
  // AXI master
  //////////////////////////////////////////////////

  // Order 0 AW with W, 1 AW first, 2 W first
  task automatic axi_write(input ps_bus_pkg::sys_addr_t addr,
                           input ps_bus_pkg::sys_data_t data,
                           input ps_bus_pkg::sys_sel_t strb,
                           input ps_bus_pkg::axi_id_t id,
                           input int order, input int bdelay,
                           output ps_bus_pkg::axi_resp_t resp,
                           output ps_bus_pkg::axi_id_t bid);
    bit aw_done, w_done, aw_hs, w_hs;
    int lat;
    aw_done = 1'b0;
    w_done  = 1'b0;
    @(negedge clk);
    if (order != 2) begin
      awvalid = 1'b1;
      awaddr  = addr;
      awid    = id;
    end
    if (order != 1) begin
      wvalid = 1'b1;
      wdata  = data;
      wstrb  = strb;
    end
    while (!(aw_done && w_done)) begin
      aw_hs = awvalid && awready_o;
      w_hs  = wvalid && wready_o;
      @(negedge clk);
      if (aw_hs) begin
        awvalid = 1'b0;
        aw_done = 1'b1;
      end
      if (w_hs) begin
        wvalid = 1'b0;
        w_done = 1'b1;
      end
      // Second channel once the first is taken
      if (aw_done && !w_done && !wvalid) begin
        wvalid = 1'b1;
        wdata  = data;
        wstrb  = strb;
      end
      if (w_done && !aw_done && !awvalid) begin
        awvalid = 1'b1;
        awaddr  = addr;
        awid    = id;
      end
    end
    // Both channels in since the last rising edge
    lat = 0;
    while (!bvalid_o) begin
      @(negedge clk);
      lat++;
    end
    check_value("write latency", lat, 3);
    resp = bresp_o;
    bid  = bid_o;
    repeat (bdelay) begin
      @(negedge clk);
      check_true(bvalid_o && bresp_o === resp && bid_o === bid,
                 "write response changed while bready_i low");
      check_true(!awready_o && !wready_o && !arready_o,
                 "channel ready high while the write response is pending");
    end
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
    check_true(!bvalid_o, "bvalid_o still high after handshake");
  endtask

  task automatic axi_read(input ps_bus_pkg::sys_addr_t addr,
                          input ps_bus_pkg::axi_id_t id, input int rdelay,
                          output ps_bus_pkg::axi_resp_t resp,
                          output ps_bus_pkg::axi_id_t rid,
                          output ps_bus_pkg::sys_data_t data);
    int lat;
    @(negedge clk);
    arvalid = 1'b1;
    araddr  = addr;
    arid    = id;
    while (!arready_o) @(negedge clk);
    @(negedge clk);
    arvalid = 1'b0;
    lat = 0;
    while (!rvalid_o) begin
      @(negedge clk);
      lat++;
    end
    check_value("read latency", lat, 3);
    resp = rresp_o;
    rid  = rid_o;
    data = rdata_o;
    repeat (rdelay) begin
      @(negedge clk);
      check_true(rvalid_o && rresp_o === resp && rid_o === rid && rdata_o === data,
                 "read data changed while rready_i low");
      check_true(!awready_o && !wready_o && !arready_o,
                 "channel ready high while the read data is pending");
    end
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
    check_true(!rvalid_o, "rvalid_o still high after handshake");
  endtask

  task automatic write_check(input int region, input int ofs, input logic [31:0] data,
                             input logic [3:0] strb, input int order, input int bdelay,
                             input ps_bus_pkg::axi_resp_t exp_resp);
    ps_bus_pkg::axi_id_t   id, bid;
    ps_bus_pkg::axi_resp_t resp;
    id = rand_bits(`AXI_IW);
    axi_write(addr_of(region, ofs), data, strb, id, order, bdelay, resp, bid);
    check_value("bresp_o", resp, exp_resp);
    check_value("bid_o", bid, id);
  endtask

  // Data compared only on OKAY
  task automatic read_check(input int region, input int ofs, input logic [31:0] exp_data,
                            input ps_bus_pkg::axi_resp_t exp_resp, input int rdelay);
    ps_bus_pkg::axi_id_t   id, rid;
    ps_bus_pkg::axi_resp_t resp;
    ps_bus_pkg::sys_data_t data;
    id = rand_bits(`AXI_IW);
    axi_read(addr_of(region, ofs), id, rdelay, resp, rid, data);
    check_value("rresp_o", resp, exp_resp);
    check_value("rid_o", rid, id);
    if (exp_resp == ps_bus_pkg::OKAY) check_value("rdata_o", data, exp_data);
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic after_reset();
    check_value("bvalid_o", bvalid_o, 0);
    check_value("rvalid_o", rvalid_o, 0);
    check_value("gpio_o", gpio_o, 0);
    // Idle bridge takes any channel
    check_value("awready_o", awready_o, 1);
    check_value("wready_o", wready_o, 1);
    check_value("arready_o", arready_o, 1);
    for (int r = 0; r < 2; r++) read_check(r, 'h4, 0, ps_bus_pkg::OKAY, 0);
  endtask

  task automatic id_reads();
    read_check(0, 'h0, ID_VAL[0], ps_bus_pkg::OKAY, 1);
    read_check(1, 'h0, ID_VAL[1], ps_bus_pkg::OKAY, 2);
  endtask

  task automatic scratch_merge();
    int          r, order, bdelay, rdelay;
    logic [31:0] data;
    logic [3:0]  strb;
    repeat (8) begin
      r      = rand_bits(1);
      data   = rand_bits(32);
      strb   = rand_bits(4);
      order  = rand_bits(2) % 3;
      bdelay = rand_bits(2);
      rdelay = rand_bits(2);
      write_check(r, 'h4, data, strb, order, bdelay, ps_bus_pkg::OKAY);
      scr_model[r] = merge_bytes(scr_model[r], data, strb);
      read_check(r, 'h4, scr_model[r], ps_bus_pkg::OKAY, rdelay);
    end
  endtask

  task automatic gpio_paths();
    logic [7:0] val, pins;
    for (int r = 0; r < 2; r++) begin
      val = rand_bits(8);
      write_check(r, 'h8, {24'h0, val}, 4'hf, 0, 0, ps_bus_pkg::OKAY);
      gpo_model[r] = val;
      check_value("gpio_o", gpio_o, {gpo_model[1], gpo_model[0]});
      read_check(r, 'h8, {24'h0, val}, ps_bus_pkg::OKAY, 0);
      // Pins settle well past the synchronizer
      pins = rand_bits(8);
      @(negedge clk);
      gpio_i[8*r +: 8] = pins;
      repeat (4) @(negedge clk);
      read_check(r, 'hc, {24'h0, pins}, ps_bus_pkg::OKAY, 0);
    end
  endtask

  task automatic error_responses();
    logic [15:0] gpio_before;
    gpio_before = gpio_o;
    // Unmapped regions
    for (int r = 2; r < 4; r++) begin
      write_check(r, 'h4, rand_bits(32), 4'hf, 0, 0, ps_bus_pkg::SLVERR);
      read_check(r, 'h0, 0, ps_bus_pkg::SLVERR, 0);
    end
    // Read only registers
    for (int r = 0; r < 2; r++) begin
      write_check(r, 'h0, rand_bits(32), 4'hf, 0, 0, ps_bus_pkg::SLVERR);
      write_check(r, 'hc, rand_bits(32), 4'hf, 0, 0, ps_bus_pkg::SLVERR);
    end
    // Undefined offset
    write_check(0, 'h10, rand_bits(32), 4'hf, 0, 0, ps_bus_pkg::SLVERR);
    read_check(1, 'h10, 0, ps_bus_pkg::SLVERR, 0);
    check_value("gpio_o", gpio_o, gpio_before);
    for (int r = 0; r < 2; r++) begin
      read_check(r, 'h0, ID_VAL[r], ps_bus_pkg::OKAY, 0);
      read_check(r, 'h4, scr_model[r], ps_bus_pkg::OKAY, 0);
      read_check(r, 'h8, {24'h0, gpo_model[r]}, ps_bus_pkg::OKAY, 0);
    end
  endtask

  // Channel order and back-pressure
  task automatic channel_order();
    logic [31:0] data;
    for (int o = 0; o < 3; o++) begin
      data = rand_bits(32);
      write_check(o % 2, 'h4, data, 4'hf, o, 5, ps_bus_pkg::OKAY);
      scr_model[o % 2] = data;
      read_check(o % 2, 'h4, data, ps_bus_pkg::OKAY, 5);
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    awvalid = 1'b0;
    awaddr  = '0;
    awid    = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    arvalid = 1'b0;
    araddr  = '0;
    arid    = '0;
    bready  = 1'b0;
    rready  = 1'b0;
    gpio_i  = '0;
    scr_model = '{32'h0, 32'h0};
    gpo_model = '{8'h0, 8'h0};
    repeat (RST_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    after_reset();
    id_reads();
    scratch_merge();
    gpio_paths();
    error_responses();
    channel_order();
    @(negedge clk);
    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    #((N_TRANS * 40 + RST_CYCLES) * CLK_PERIOD);
    $display("Timeout: tests did not finish within %0d cycles",
             N_TRANS * 40 + RST_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+hdl
hdl/ps_bus_pkg.sv
hdl/sys_bus_if.sv
hdl/axi4_slave.sv
hdl/sys_bus_interconnect.sv
hdl/sys_bus_regs.sv
hdl/red_pitaya_ps_sys.sv
test/tb_red_pitaya_ps_sys.sv

// File: Bender.yml
package:
  name: red_pitaya_ps_sys

export_include_dirs:
  - hdl

sources:
  # RTL in compile order
  - include_dirs:
      - hdl
    files:
      - hdl/ps_bus_pkg.sv
      - hdl/sys_bus_if.sv
      - hdl/axi4_slave.sv
      - hdl/sys_bus_interconnect.sv
      - hdl/sys_bus_regs.sv
      - hdl/red_pitaya_ps_sys.sv
  # Testbench
  - target: test
    include_dirs:
      - hdl
    files:
      - test/tb_red_pitaya_ps_sys.sv
